// File: sim.f
+incdir+common
+incdir+tests
common/lc4_pkg.sv
rtl/lc4_alu.sv
rtl/lc4_regfile.sv
lc4_core/lc4_decoder.sv
lc4_core/lc4_hazard_unit.sv
lc4_core/lc4_processor.sv
tests/lc4_asserts.sv
tests/lc4_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = lc4_tb
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tests/lc4_tb_model.svh
// Testbench model of the LC4 subset: encoders, program generators and the reference step
`ifndef LC4_TB_MODEL_SVH
`define LC4_TB_MODEL_SVH

localparam logic [3:0] OPC_ARITH   = 4'd1;
localparam logic [3:0] OPC_LOGIC   = 4'd5;
localparam logic [3:0] OPC_LDR     = 4'd6;
localparam logic [3:0] OPC_STR     = 4'd7;
localparam logic [3:0] OPC_CONST   = 4'd9;
localparam logic [3:0] OPC_HICONST = 4'd13;

// Expected writeback trace of one instruction
typedef struct packed {
   logic [15:0] pc;
   logic [15:0] insn;
   logic        rf_we;
   logic [2:0]  wsel;
   logic [15:0] data;
   logic        nzp_we;
   logic [2:0]  nzp;
   logic        dmem_we;
   logic [15:0] daddr;
   logic [15:0] ddata;
} trace_t;

logic [15:0] prog [$];
logic [15:0] mdl_regs [8];
logic [2:0]  mdl_nzp;
logic [15:0] mdl_mem [65536];

// Data memory fill, every address bit shows in the word
function automatic logic [15:0] fill_word(input logic [15:0] a);
   return {a[7:0], a[15:8]} ^ 16'h3c5a;
endfunction

function automatic logic [15:0] enc_rr(input logic [3:0] op, input logic [2:0] rd,
                                       input logic [2:0] rs, input logic [2:0] sub,
                                       input logic [2:0] rt);
   return {op, rd, rs, sub, rt};
endfunction

function automatic logic [15:0] enc_ri(input logic [3:0] op, input logic [2:0] rd,
                                       input logic [2:0] rs, input logic [4:0] imm5);
   return {op, rd, rs, 1'b1, imm5};
endfunction

function automatic logic [15:0] enc_mem(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [5:0] imm6);
   return {op, rd, rs, imm6};
endfunction

function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm9);
   return {OPC_CONST, rd, imm9};
endfunction

function automatic logic [15:0] enc_hiconst(input logic [2:0] rd, input logic [7:0] imm8);
   return {OPC_HICONST, rd, 1'b1, imm8};
endfunction

// True when insn is a real instruction that reads register r
function automatic bit reads_reg(input logic [15:0] insn, input logic [2:0] r);
   logic [3:0] opc;
   logic [2:0] rd;
   logic [2:0] rs;
   logic [2:0] rt;
   logic [2:0] sub;
   opc = insn[15:12];
   rd  = insn[11:9];
   rs  = insn[8:6];
   sub = insn[5:3];
   rt  = insn[2:0];
   case (opc)
      OPC_ARITH, OPC_LOGIC: begin
         if (insn[5]) begin
            return rs == r;
         end
         if (sub == 3'd0 || sub == 3'd2 || (opc == OPC_LOGIC && sub == 3'd3)) begin
            return rs == r || rt == r;
         end
         return 0;
      end
      OPC_LDR:     return rs == r;
      OPC_STR:     return rs == r || rd == r;
      OPC_HICONST: return insn[8] && rd == r;
      default:     return 0;
   endcase
endfunction

// Each load followed by a reader of its target costs one bubble
function automatic int count_load_stalls();
   int n;
   logic [15:0] nxt;
   n = 0;
   for (int i = 0; i < prog.size(); i++) begin
      nxt = (i + 1 < prog.size()) ? prog[i+1] : 16'h0000;
      if (prog[i][15:12] == OPC_LDR && reads_reg(nxt, prog[i][11:9])) begin
         n++;
      end
   end
   return n;
endfunction

// Architectural step on the model state, returns what writeback must show
function automatic trace_t ref_step(input logic [15:0] pc, input logic [15:0] insn);
   trace_t t;
   logic [3:0]  opc;
   logic [2:0]  rd;
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] addr;
   logic [15:0] val;
   logic        we;
   opc  = insn[15:12];
   rd   = insn[11:9];
   a    = mdl_regs[insn[8:6]];
   b    = mdl_regs[insn[2:0]];
   addr = a + {{10{insn[5]}}, insn[5:0]};
   val  = 16'h0000;
   we   = 1'b0;
   t    = '0;
   t.pc   = pc;
   t.insn = insn;
   case (opc)
      OPC_ARITH: begin
         we = 1'b1;
         if (insn[5]) val = a + {{11{insn[4]}}, insn[4:0]};
         else if (insn[5:3] == 3'd0) val = a + b;
         else if (insn[5:3] == 3'd2) val = a - b;
         else we = 1'b0;
      end
      OPC_LOGIC: begin
         we = 1'b1;
         if (insn[5]) val = a & {{11{insn[4]}}, insn[4:0]};
         else if (insn[5:3] == 3'd0) val = a & b;
         else if (insn[5:3] == 3'd2) val = a | b;
         else if (insn[5:3] == 3'd3) val = a ^ b;
         else we = 1'b0;
      end
      OPC_LDR: begin
         we      = 1'b1;
         val     = mdl_mem[addr];
         t.daddr = addr;
         t.ddata = val;
      end
      OPC_STR: begin
         t.dmem_we = 1'b1;
         t.daddr   = addr;
         t.ddata   = mdl_regs[rd];
         mdl_mem[addr] = mdl_regs[rd];
      end
      OPC_CONST: begin
         we  = 1'b1;
         val = {{7{insn[8]}}, insn[8:0]};
      end
      OPC_HICONST: begin
         we  = insn[8];
         val = {insn[7:0], mdl_regs[rd][7:0]};
      end
      default: we = 1'b0;
   endcase
   if (we) begin
      mdl_regs[rd] = val;
      mdl_nzp = val[15] ? 3'b100 : (val == 16'h0000) ? 3'b010 : 3'b001;
   end
   t.rf_we  = we;
   t.wsel   = rd;
   t.data   = val;
   t.nzp_we = we;
   t.nzp    = mdl_nzp;
   return t;
endfunction

task automatic gen_reset_prog();
   prog.push_back(enc_const(3'd1, 9'h012));
   prog.push_back(16'h0000);
   prog.push_back(enc_ri(OPC_ARITH, 3'd2, 3'd1, 5'd3));
endtask

// Back-to-back dependencies hit MX, WX and the regfile bypass
task automatic gen_alu_prog();
   prog.push_back(enc_const(3'd1, 9'h005));
   prog.push_back(enc_const(3'd2, 9'h1fd));
   prog.push_back(enc_rr(OPC_ARITH, 3'd3, 3'd1, 3'd0, 3'd2));
   prog.push_back(enc_rr(OPC_ARITH, 3'd4, 3'd3, 3'd2, 3'd1));
   prog.push_back(enc_ri(OPC_ARITH, 3'd4, 3'd4, 5'h19));
   prog.push_back(enc_hiconst(3'd4, 8'h80));
   prog.push_back(enc_rr(OPC_LOGIC, 3'd5, 3'd4, 3'd0, 3'd1));
   prog.push_back(16'h0000);
   prog.push_back(enc_rr(OPC_LOGIC, 3'd6, 3'd5, 3'd2, 3'd4));
   prog.push_back(enc_rr(OPC_LOGIC, 3'd7, 3'd6, 3'd3, 3'd3));
   prog.push_back(enc_ri(OPC_LOGIC, 3'd7, 3'd7, 5'h0f));
   prog.push_back(enc_hiconst(3'd7, 8'h3c));
   prog.push_back(enc_rr(OPC_ARITH, 3'd0, 3'd7, 3'd2, 3'd7));
endtask

task automatic gen_mem_prog();
   prog.push_back(enc_const(3'd1, 9'h020));
   prog.push_back(enc_const(3'd2, 9'h155));
   prog.push_back(enc_mem(OPC_STR, 3'd2, 3'd1, 6'd0));
   prog.push_back(enc_mem(OPC_STR, 3'd1, 3'd1, 6'd5));
   prog.push_back(enc_mem(OPC_STR, 3'd2, 3'd1, 6'h3e));
   prog.push_back(enc_mem(OPC_LDR, 3'd3, 3'd1, 6'd0));
   prog.push_back(16'h0000);
   prog.push_back(enc_mem(OPC_LDR, 3'd4, 3'd1, 6'd5));
   prog.push_back(enc_mem(OPC_LDR, 3'd5, 3'd1, 6'h3e));
   prog.push_back(enc_mem(OPC_LDR, 3'd6, 3'd1, 6'd9));
endtask

task automatic gen_load_use_prog();
   prog.push_back(enc_const(3'd1, 9'h040));
   prog.push_back(enc_mem(OPC_LDR, 3'd2, 3'd1, 6'd3));
   prog.push_back(enc_rr(OPC_ARITH, 3'd3, 3'd2, 3'd0, 3'd2));
   prog.push_back(enc_mem(OPC_LDR, 3'd4, 3'd1, 6'd1));
   prog.push_back(enc_mem(OPC_STR, 3'd4, 3'd1, 6'd2));
   prog.push_back(enc_mem(OPC_LDR, 3'd5, 3'd1, 6'd2));
   prog.push_back(enc_const(3'd6, 9'h001));
   prog.push_back(enc_rr(OPC_ARITH, 3'd7, 3'd5, 3'd0, 3'd5));
   prog.push_back(enc_mem(OPC_LDR, 3'd5, 3'd1, 6'd0));
   prog.push_back(enc_hiconst(3'd5, 8'h12));
   prog.push_back(enc_mem(OPC_LDR, 3'd1, 3'd1, 6'd4));
   prog.push_back(enc_mem(OPC_LDR, 3'd2, 3'd1, 6'd0));
endtask

task automatic gen_nzp_prog();
   prog.push_back(enc_const(3'd1, 9'h000));
   prog.push_back(enc_const(3'd2, 9'h1ff));
   prog.push_back(16'h0000);
   prog.push_back(enc_ri(OPC_ARITH, 3'd3, 3'd2, 5'd2));
   prog.push_back(enc_mem(OPC_STR, 3'd3, 3'd1, 6'd7));
   prog.push_back(enc_rr(OPC_ARITH, 3'd4, 3'd1, 3'd2, 3'd3));
   prog.push_back(enc_rr(OPC_LOGIC, 3'd5, 3'd2, 3'd3, 3'd2));
   prog.push_back(16'h0000);
endtask

task automatic gen_random_prog(input int n);
   logic [31:0] r;
   for (int i = 0; i < n; i++) begin
      r = $urandom;
      case (r[31:28] % 4'd9)
         4'd0: prog.push_back(enc_rr(OPC_ARITH, r[2:0], r[5:3], 3'd0, r[8:6]));
         4'd1: prog.push_back(enc_rr(OPC_ARITH, r[2:0], r[5:3], 3'd2, r[8:6]));
         4'd2: prog.push_back(enc_ri(OPC_ARITH, r[2:0], r[5:3], r[13:9]));
         4'd3: prog.push_back(enc_rr(OPC_LOGIC, r[2:0], r[5:3], {1'b0, r[9], r[10]}, r[8:6]));
         4'd4: prog.push_back(enc_ri(OPC_LOGIC, r[2:0], r[5:3], r[13:9]));
         4'd5: prog.push_back(enc_mem(OPC_LDR, r[2:0], r[5:3], r[14:9]));
         4'd6: prog.push_back(enc_mem(OPC_STR, r[2:0], r[5:3], r[14:9]));
         4'd7: prog.push_back(enc_const(r[2:0], r[17:9]));
         default: prog.push_back(enc_hiconst(r[2:0], r[16:9]));
      endcase
   end
endtask

`endif

// File: tests/lc4_tb.sv
// Testbench top for the LC4 pipeline; runs directed and random programs against a model
`timescale 1ns/1ns
`include "lc4_config.svh"

module lc4_tb;

   logic        gwe;
   logic        i_rst_n;
   logic [15:0] o_imem_addr;
   logic [15:0] i_imem_data;
   logic [15:0] o_dmem_addr;
   logic        o_dmem_we;
   logic [15:0] o_dmem_wdata;
   logic [15:0] i_dmem_rdata;
   logic [1:0]  o_wb_stall;
   logic [15:0] o_wb_pc;
   logic [15:0] o_wb_insn;
   logic        o_wb_rf_we;
   logic [2:0]  o_wb_rf_wsel;
   logic [15:0] o_wb_rf_data;
   logic        o_wb_nzp_we;
   logic [2:0]  o_wb_nzp_bits;
   logic        o_wb_dmem_we;
   logic [15:0] o_wb_dmem_addr;
   logic [15:0] o_wb_dmem_data;

   logic [15:0] imem [65536];
   logic [15:0] dmem [65536];

   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int retired;
   int bubbles;
   int flush_seen;
   bit check_en;

   `include "lc4_tb_model.svh"

   lc4_processor lc4_processor_i (.*);

   always #4 gwe = ~gwe;

   // Both memories answer in the same cycle
   assign i_imem_data  = imem[o_imem_addr];
   assign i_dmem_rdata = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we) begin
         dmem[o_dmem_addr] <= o_dmem_wdata;
      end
   end

   task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Sampled at the falling edge, half a cycle clear of the update
   always @(negedge gwe) begin
      trace_t exp;
      logic [15:0] insn;
      if (check_en) begin
         if (o_wb_stall == `LC4_STALL_NONE) begin
            if (retired == 0) begin
               check_eq("flush bubbles after reset", 16'(flush_seen), 16'd4);
            end
            insn = (retired < prog.size()) ? prog[retired] : 16'h0000;
            exp  = ref_step(`LC4_RESET_PC + 16'(retired), insn);
            check_eq("o_wb_pc", o_wb_pc, exp.pc);
            check_eq("o_wb_insn", o_wb_insn, exp.insn);
            check_eq("o_wb_rf_we", 16'(o_wb_rf_we), 16'(exp.rf_we));
            if (exp.rf_we) begin
               check_eq("o_wb_rf_wsel", 16'(o_wb_rf_wsel), 16'(exp.wsel));
               check_eq("o_wb_rf_data", o_wb_rf_data, exp.data);
            end
            check_eq("o_wb_nzp_we", 16'(o_wb_nzp_we), 16'(exp.nzp_we));
            check_eq("o_wb_nzp_bits", 16'(o_wb_nzp_bits), 16'(exp.nzp));
            check_eq("o_wb_dmem_we", 16'(o_wb_dmem_we), 16'(exp.dmem_we));
            check_eq("o_wb_dmem_addr", o_wb_dmem_addr, exp.daddr);
            check_eq("o_wb_dmem_data", o_wb_dmem_data, exp.ddata);
            retired++;
         end else if (o_wb_stall == `LC4_STALL_LOAD ||
                      (o_wb_stall == `LC4_STALL_FLUSH && retired == 0)) begin
            if (o_wb_stall == `LC4_STALL_LOAD) bubbles++;
            else flush_seen++;
            check_eq("bubble write enables",
                     16'({o_wb_rf_we, o_wb_nzp_we, o_wb_dmem_we}), 16'd0);
         end else begin
            errors++;
            $display("ERROR at %0t: unexpected stall code %0d in writeback", $time, o_wb_stall);
         end
      end
   end

   // Reset, load both memories and the model, then retire the whole program
   task automatic run_test(input string name);
      int errs_before;
      int exp_stalls;
      int cycles;
      errs_before = errors;
      exp_stalls  = count_load_stalls();
      @(posedge gwe);
      #1;
      i_rst_n = 1'b0;
      @(posedge gwe);
      #1;
      for (int a = 0; a < 65536; a++) begin
         imem[a]    = 16'h0000;
         dmem[a]    = fill_word(16'(a));
         mdl_mem[a] = fill_word(16'(a));
      end
      foreach (prog[i]) imem[`LC4_RESET_PC + 16'(i)] = prog[i];
      foreach (mdl_regs[i]) mdl_regs[i] = 16'h0000;
      mdl_nzp    = 3'b000;
      retired    = 0;
      bubbles    = 0;
      flush_seen = 0;
      repeat (4) @(posedge gwe);
      #1;
      i_rst_n  = 1'b1;
      check_en = 1'b1;
      cycles   = 0;
      while (retired < prog.size() && cycles < 3 * prog.size() + 20) begin
         @(posedge gwe);
         cycles++;
      end
      check_en = 1'b0;
      if (retired < prog.size()) begin
         errors++;
         $display("ERROR: %s timed out with %0d of %0d instructions retired",
                  name, retired, prog.size());
      end
      if (bubbles != exp_stalls) begin
         errors++;
         $display("ERROR: %s saw %0d load-use bubbles where %0d were expected",
                  name, bubbles, exp_stalls);
      end
      tests_run++;
      if (errors != errs_before) tests_failed++;
      $display("Test %-9s retired %0d, load-use bubbles %0d: %s",
               name, retired, bubbles, (errors == errs_before) ? "ok" : "FAIL");
      prog.delete();
   endtask

   initial begin
      void'($urandom(32'hfd80_9a18));
      gwe      = 1'b0;
      i_rst_n  = 1'b0;
      check_en = 1'b0;
      gen_reset_prog();
      run_test("reset");
      gen_alu_prog();
      run_test("alu");
      gen_mem_prog();
      run_test("ldst");
      gen_load_use_prog();
      run_test("load_use");
      gen_nzp_prog();
      run_test("nzp");
      gen_random_prog(200);
      run_test("random");
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: tests/lc4_asserts.sv
// Bound assertions on the LC4 core: memory enables, trace bubbles and PC hold on stall
`timescale 1ns/1ns

module lc4_asserts (
   input logic        gwe,
   input logic        i_rst_n,
   input logic        i_dmem_we,
   input logic        i_m_load,
   input logic [1:0]  i_wb_stall,
   input logic        i_wb_rf_we,
   input logic        i_wb_nzp_we,
   input logic        i_wb_dmem_we,
   input logic        i_stall,
   input logic [15:0] i_pc
);

   // A load in M never drives a write
   a_no_store_on_load: assert property (@(posedge gwe) disable iff (!i_rst_n)
      !(i_dmem_we && i_m_load))
      else $error("dmem write enable high with a load in M");

   // Bubbles write nothing
   a_bubble_quiet: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (i_wb_stall != 2'd0) |-> !(i_wb_rf_we || i_wb_nzp_we || i_wb_dmem_we))
      else $error("write enable set on a writeback bubble");

   a_pc_holds: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_stall |=> $stable(i_pc))
      else $error("PC moved during a load-use stall");

endmodule

bind lc4_processor lc4_asserts lc4_asserts_i (
   .gwe          (gwe),
   .i_rst_n      (i_rst_n),
   .i_dmem_we    (o_dmem_we),
   .i_m_load     (xm_ctrl.is_load),
   .i_wb_stall   (o_wb_stall),
   .i_wb_rf_we   (o_wb_rf_we),
   .i_wb_nzp_we  (o_wb_nzp_we),
   .i_wb_dmem_we (o_wb_dmem_we),
   .i_stall      (stall),
   .i_pc         (pc_q)
);

// File: lc4_core/lc4_processor.sv
// Five-stage LC4 subset core, top level; instantiated by the testbench with its memories
`timescale 1ns/1ns
`include "lc4_config.svh"

module lc4_processor (
   input  logic              gwe,
   input  logic              i_rst_n,
   output lc4_pkg::word_t    o_imem_addr,
   input  lc4_pkg::word_t    i_imem_data,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_wdata,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output logic [1:0]        o_wb_stall,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_rf_we,
   output lc4_pkg::reg_idx_t o_wb_rf_wsel,
   output lc4_pkg::word_t    o_wb_rf_data,
   output logic              o_wb_nzp_we,
   output logic [2:0]        o_wb_nzp_bits,
   output logic              o_wb_dmem_we,
   output lc4_pkg::word_t    o_wb_dmem_addr,
   output lc4_pkg::word_t    o_wb_dmem_data
);
   import lc4_pkg::*;

   word_t      pc_q;
   logic       stall;
   logic [1:0] fd_stall;
   word_t      fd_pc;
   word_t      fd_insn;
   ctrl_t      dec_ctrl;
   ctrl_t      d_ctrl;
   word_t      rf_rs_data;
   word_t      rf_rt_data;
   logic [1:0] dx_stall;
   word_t      dx_pc;
   word_t      dx_insn;
   ctrl_t      dx_ctrl;
   word_t      dx_rs_data;
   word_t      dx_rt_data;
   logic [1:0] rs_sel;
   logic [1:0] rt_sel;
   word_t      x_rs;
   word_t      x_rt;
   word_t      alu_result;
   logic [1:0] xm_stall;
   word_t      xm_pc;
   word_t      xm_insn;
   ctrl_t      xm_ctrl;
   word_t      xm_alu;
   word_t      xm_rt_data;
   logic       xm_mem_op;
   logic [1:0] mw_stall;
   word_t      mw_pc;
   word_t      mw_insn;
   ctrl_t      mw_ctrl;
   word_t      mw_alu;
   word_t      mw_mem_addr;
   word_t      mw_mem_data;
   word_t      wb_data;
   logic [2:0] nzp_q;
   logic [2:0] nzp_new;
   logic       x_valid;
   logic       m_valid;
   logic       w_valid;

   // Fetch, PC and F/D both freeze on a load-use stall
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc_q     <= `LC4_RESET_PC;
         fd_stall <= `LC4_STALL_FLUSH;
      end else if (!stall) begin
         pc_q     <= pc_q + word_t'(1);
         fd_stall <= `LC4_STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      if (!stall) begin
         fd_pc   <= pc_q;
         fd_insn <= i_imem_data;
      end
   end

   assign o_imem_addr = pc_q;

   // Decode
   lc4_decoder lc4_decoder_i (
      .i_insn (fd_insn),
      .o_ctrl (dec_ctrl)
   );

   // A flush bubble in D must not write or trigger a stall
   assign d_ctrl = (fd_stall == `LC4_STALL_NONE) ? dec_ctrl : '0;

   lc4_regfile lc4_regfile_i (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (d_ctrl.rs),
      .i_rt      (d_ctrl.rt),
      .i_rd      (mw_ctrl.rd),
      .i_wdata   (wb_data),
      .i_we      (mw_ctrl.rf_we),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   assign x_valid = (dx_stall == `LC4_STALL_NONE);
   assign m_valid = (xm_stall == `LC4_STALL_NONE);
   assign w_valid = (mw_stall == `LC4_STALL_NONE);

   lc4_hazard_unit lc4_hazard_unit_i (
      .i_ctrl_d  (d_ctrl),
      .i_ctrl_x  (dx_ctrl),
      .i_ctrl_m  (xm_ctrl),
      .i_ctrl_w  (mw_ctrl),
      .i_valid_x (x_valid),
      .i_valid_m (m_valid),
      .i_valid_w (w_valid),
      .o_stall   (stall),
      .o_rs_sel  (rs_sel),
      .o_rt_sel  (rt_sel)
   );

   // D/X, a stall drops a code 3 bubble in behind the load
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         dx_stall <= `LC4_STALL_FLUSH;
         dx_ctrl  <= '0;
      end else if (stall) begin
         dx_stall <= `LC4_STALL_LOAD;
         dx_ctrl  <= '0;
      end else begin
         dx_stall <= fd_stall;
         dx_ctrl  <= d_ctrl;
      end
   end

   always_ff @(posedge gwe) begin
      dx_pc      <= fd_pc;
      dx_insn    <= stall ? '0 : fd_insn;
      dx_rs_data <= rf_rs_data;
      dx_rt_data <= rf_rt_data;
   end

   // Execute with MX and WX bypass
   assign x_rs = (rs_sel == BYP_M) ? xm_alu : (rs_sel == BYP_W) ? wb_data : dx_rs_data;
   assign x_rt = (rt_sel == BYP_M) ? xm_alu : (rt_sel == BYP_W) ? wb_data : dx_rt_data;

   lc4_alu lc4_alu_i (
      .i_op      (dx_ctrl.alu_op),
      .i_a       (x_rs),
      .i_b       (x_rt),
      .i_imm     (dx_ctrl.imm),
      .i_use_imm (dx_ctrl.use_imm),
      .o_result  (alu_result)
   );

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         xm_stall <= `LC4_STALL_FLUSH;
         xm_ctrl  <= '0;
      end else begin
         xm_stall <= dx_stall;
         xm_ctrl  <= dx_ctrl;
      end
   end

   always_ff @(posedge gwe) begin
      xm_pc      <= dx_pc;
      xm_insn    <= dx_insn;
      xm_alu     <= alu_result;
      xm_rt_data <= x_rt;
   end

   // Memory stage, bus idles at zero unless a load or store is here
   assign xm_mem_op    = xm_ctrl.is_load | xm_ctrl.is_store;
   assign o_dmem_addr  = xm_mem_op ? xm_alu : '0;
   assign o_dmem_we    = xm_ctrl.is_store;
   assign o_dmem_wdata = xm_ctrl.is_store ? xm_rt_data : '0;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         mw_stall <= `LC4_STALL_FLUSH;
         mw_ctrl  <= '0;
      end else begin
         mw_stall <= xm_stall;
         mw_ctrl  <= xm_ctrl;
      end
   end

   // Memory data kept for the trace: load data or store data
   always_ff @(posedge gwe) begin
      mw_pc       <= xm_pc;
      mw_insn     <= xm_insn;
      mw_alu      <= xm_alu;
      mw_mem_addr <= o_dmem_addr;
      mw_mem_data <= xm_ctrl.is_load ? i_dmem_rdata : o_dmem_wdata;
   end

   // Writeback
   assign wb_data = mw_ctrl.is_load ? mw_mem_data : mw_alu;
   assign nzp_new = wb_data[`LC4_XLEN-1] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp_q <= 3'b000;
      end else if (mw_ctrl.nzp_we) begin
         nzp_q <= nzp_new;
      end
   end

   // Trace shows the held flags when nothing writes them
   assign o_wb_stall     = mw_stall;
   assign o_wb_pc        = mw_pc;
   assign o_wb_insn      = mw_insn;
   assign o_wb_rf_we     = mw_ctrl.rf_we;
   assign o_wb_rf_wsel   = mw_ctrl.rd;
   assign o_wb_rf_data   = wb_data;
   assign o_wb_nzp_we    = mw_ctrl.nzp_we;
   assign o_wb_nzp_bits  = mw_ctrl.nzp_we ? nzp_new : nzp_q;
   assign o_wb_dmem_we   = mw_ctrl.is_store;
   assign o_wb_dmem_addr = mw_mem_addr;
   assign o_wb_dmem_data = mw_mem_data;

endmodule

// File: lc4_core/lc4_hazard_unit.sv
// Load-use stall and MX/WX bypass select logic for the core pipeline
`timescale 1ns/1ns

module lc4_hazard_unit (
   input  lc4_pkg::ctrl_t i_ctrl_d,
   input  lc4_pkg::ctrl_t i_ctrl_x,
   input  lc4_pkg::ctrl_t i_ctrl_m,
   input  lc4_pkg::ctrl_t i_ctrl_w,
   input  logic           i_valid_x,
   input  logic           i_valid_m,
   input  logic           i_valid_w,
   output logic           o_stall,
   output logic [1:0]     o_rs_sel,
   output logic [1:0]     o_rt_sel
);
   import lc4_pkg::*;

   logic load_in_x;
   logic m_writes;
   logic w_writes;

   // Youngest producer wins so M beats W and W beats the register file
   function automatic logic [1:0] pick_src(input reg_idx_t src, input logic re);
      logic [1:0] sel;
      sel = BYP_RF;
      if (re && m_writes && (i_ctrl_m.rd == src)) begin
         sel = BYP_M;
      end else if (re && w_writes && (i_ctrl_w.rd == src)) begin
         sel = BYP_W;
      end
      return sel;
   endfunction

   assign load_in_x = i_valid_x & i_ctrl_x.is_load & i_ctrl_x.rf_we;
   assign m_writes  = i_valid_m & i_ctrl_m.rf_we;
   assign w_writes  = i_valid_w & i_ctrl_w.rf_we;

   // Load data is not ready until W, so D waits one cycle
   assign o_stall = load_in_x &
                    ((i_ctrl_d.rs_re & (i_ctrl_d.rs == i_ctrl_x.rd)) |
                     (i_ctrl_d.rt_re & (i_ctrl_d.rt == i_ctrl_x.rd)));

   // Operand selects for the instruction in X
   always_comb begin
      o_rs_sel = pick_src(i_ctrl_x.rs, i_ctrl_x.rs_re);
      o_rt_sel = pick_src(i_ctrl_x.rt, i_ctrl_x.rt_re);
   end

endmodule

// File: lc4_core/lc4_decoder.sv
// Instruction decoder for the kept LC4 subset, used in the D stage of the core
`timescale 1ns/1ns
`include "lc4_config.svh"

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t o_ctrl
);
   import lc4_pkg::*;

   insn_u insn;
   ctrl_t ctrl;
   word_t imm5_sext;
   word_t imm6_sext;
   word_t imm9_sext;
   word_t imm8_zext;

   assign insn = i_insn;

   // Immediates per format
   assign imm5_sext = {{(`LC4_XLEN-5){insn.ri.imm5[4]}}, insn.ri.imm5};
   assign imm6_sext = {{(`LC4_XLEN-6){insn.mem.imm6[5]}}, insn.mem.imm6};
   assign imm9_sext = {{(`LC4_XLEN-9){insn.cst.imm9[8]}}, insn.cst.imm9};
   assign imm8_zext = {{(`LC4_XLEN-8){1'b0}}, insn.cst.imm9[7:0]};

   always_comb begin
      ctrl = '0;
      case (insn.rr.opcode)
         OP_ARITH, OP_LOGIC: begin
            ctrl.rd     = insn.rr.rd;
            ctrl.rs     = insn.rr.rs;
            ctrl.rs_re  = 1'b1;
            ctrl.rf_we  = 1'b1;
            ctrl.nzp_we = 1'b1;
            if (insn.ri.imm_flag) begin
               // ADD imm5 or AND imm5
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5_sext;
               ctrl.alu_op  = (insn.rr.opcode == OP_ARITH) ? ALU_ADD : ALU_AND;
            end else begin
               ctrl.rt    = insn.rr.rt;
               ctrl.rt_re = 1'b1;
               case ({insn.rr.opcode == OP_LOGIC, insn.rr.sub_op})
                  4'b0_000: ctrl.alu_op = ALU_ADD;
                  4'b0_010: ctrl.alu_op = ALU_SUB;
                  4'b1_000: ctrl.alu_op = ALU_AND;
                  4'b1_010: ctrl.alu_op = ALU_OR;
                  4'b1_011: ctrl.alu_op = ALU_XOR;
                  // MUL, DIV, NOT are not implemented
                  default:  ctrl = '0;
               endcase
            end
         end
         OP_LDR: begin
            ctrl.rd      = insn.mem.rd;
            ctrl.rs      = insn.mem.rs;
            ctrl.rs_re   = 1'b1;
            ctrl.rf_we   = 1'b1;
            ctrl.nzp_we  = 1'b1;
            ctrl.is_load = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = imm6_sext;
            ctrl.alu_op  = ALU_ADD;
         end
         OP_STR: begin
            // Store data register sits in the rd slot
            ctrl.rt       = insn.mem.rd;
            ctrl.rt_re    = 1'b1;
            ctrl.rs       = insn.mem.rs;
            ctrl.rs_re    = 1'b1;
            ctrl.is_store = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.imm      = imm6_sext;
            ctrl.alu_op   = ALU_ADD;
         end
         OP_CONST: begin
            ctrl.rd      = insn.cst.rd;
            ctrl.rf_we   = 1'b1;
            ctrl.nzp_we  = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = imm9_sext;
            ctrl.alu_op  = ALU_PASS_IMM;
         end
         OP_HICONST: begin
            // Bit 8 clear is not a valid HICONST
            if (insn.cst.imm9[8]) begin
               ctrl.rd      = insn.cst.rd;
               ctrl.rs      = insn.cst.rd;
               ctrl.rs_re   = 1'b1;
               ctrl.rf_we   = 1'b1;
               ctrl.nzp_we  = 1'b1;
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm8_zext;
               ctrl.alu_op  = ALU_HICONST;
            end
         end
         default: ctrl = '0;
      endcase
   end

   assign o_ctrl = ctrl;

endmodule

// File: rtl/lc4_regfile.sv
// Register file with two read ports, one write port and same-cycle write forwarding
`timescale 1ns/1ns
`include "lc4_config.svh"

module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::reg_idx_t i_rs,
   input  lc4_pkg::reg_idx_t i_rt,
   input  lc4_pkg::reg_idx_t i_rd,
   input  lc4_pkg::word_t    i_wdata,
   input  logic              i_we,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);
   import lc4_pkg::*;

   word_t regs [`LC4_NREGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `LC4_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Writeback value is seen by decode in the same cycle
   assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

// File: rtl/lc4_alu.sv
// Execute-stage ALU: arithmetic, logic, memory address and constant results
`timescale 1ns/1ns
`include "lc4_config.svh"

module lc4_alu (
   input  lc4_pkg::alu_op_e i_op,
   input  lc4_pkg::word_t   i_a,
   input  lc4_pkg::word_t   i_b,
   input  lc4_pkg::word_t   i_imm,
   input  logic             i_use_imm,
   output lc4_pkg::word_t   o_result
);
   import lc4_pkg::*;

   localparam int HALF = `LC4_XLEN / 2;

   word_t opnd_b;

   // Immediate forms replace rt
   assign opnd_b = i_use_imm ? i_imm : i_b;

   always_comb begin
      case (i_op)
         // Also LDR and STR address, rs plus imm6
         ALU_ADD:      o_result = i_a + opnd_b;
         ALU_SUB:      o_result = i_a - opnd_b;
         ALU_AND:      o_result = i_a & opnd_b;
         ALU_OR:       o_result = i_a | opnd_b;
         ALU_XOR:      o_result = i_a ^ opnd_b;
         ALU_PASS_IMM: o_result = i_imm;
         // New upper byte, rd keeps its low byte
         ALU_HICONST:  o_result = {i_imm[HALF-1:0], i_a[HALF-1:0]};
         default:      o_result = '0;
      endcase
   end

endmodule

// File: common/lc4_pkg.sv
// Shared LC4 types for the core: opcodes, instruction formats, ALU ops and decoded control
`include "lc4_config.svh"

package lc4_pkg;

   typedef logic [`LC4_XLEN-1:0] word_t;
   typedef logic [$clog2(`LC4_NREGS)-1:0] reg_idx_t;

   // Only the opcodes this core executes, everything else decodes as NOP
   typedef enum logic [3:0] {
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_LDR     = 4'b0110,
      OP_STR     = 4'b0111,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_e;

   // ALU_ADD must stay at zero, a cleared control word means add
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM,
      ALU_HICONST
   } alu_op_e;

   // Operand bypass selects from the hazard unit
   localparam logic [1:0] BYP_RF = 2'd0;
   localparam logic [1:0] BYP_M  = 2'd1;
   localparam logic [1:0] BYP_W  = 2'd2;

   // Register-register form
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic [2:0] sub_op;
      reg_idx_t   rt;
   } insn_rr_t;

   // Register-immediate form, imm_flag overlays sub_op[2]
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic       imm_flag;
      logic [4:0] imm5;
   } insn_ri_t;

   // Load and store, rd holds rt for a store
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic [5:0] imm6;
   } insn_mem_t;

   // Constants, HICONST takes imm9[7:0] with imm9[8] set
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      logic [8:0] imm9;
   } insn_cst_t;

   typedef union packed {
      insn_rr_t  rr;
      insn_ri_t  ri;
      insn_mem_t mem;
      insn_cst_t cst;
   } insn_u;

   // Decoded control, travels D to W
   typedef struct packed {
      reg_idx_t rs;
      logic     rs_re;
      reg_idx_t rt;
      logic     rt_re;
      reg_idx_t rd;
      logic     rf_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      alu_op_e  alu_op;
      logic     use_imm;
      word_t    imm;
   } ctrl_t;

endpackage

// File: common/lc4_config.svh
// Core-wide widths, reset vector and stall codes; include in any file that needs them
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// Data path and address width
`define LC4_XLEN 16

// Architectural register count
`define LC4_NREGS 8

// First fetch address out of reset
`define LC4_RESET_PC 16'h8200

// Stall codes carried with every instruction down the pipe
`define LC4_STALL_NONE  2'd0
// Reset fill bubbles
`define LC4_STALL_FLUSH 2'd2
// Bubble inserted behind a load whose result is needed next
`define LC4_STALL_LOAD  2'd3

`endif
